/* source/uart_sys_pkg.sv */
////////////////////////////////////////////////////////////
// UART command system shared types
////////////////////////////////////////////////////////////

package uart_sys_pkg;

	// width of one serial byte
	localparam int BYTE_W = 8;

	// upper nibble of a command byte, all other values are unknown
	typedef enum logic [3:0] {
		OP_SET_LED = 4'd1, // lower nibble goes to the leds
		OP_READ_SW = 4'd2, // reply carries the debounced switches
		OP_PING    = 4'd3  // reply echoes the command
	} cmd_op_e;

	// reply for any opcode the engine does not know
	localparam logic [BYTE_W-1:0] REPLY_BAD = 8'hEE;

	// receiver walks the bit midpoints of one frame
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// transmitter frame states, one bit time each except data
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

endpackage

/* source/uart_rx.sv */
////////////////////////////////////////////////////////////
// UART serial receiver
////////////////////////////////////////////////////////////

module uart_rx #(
	parameter int CLK_PER_BIT = 16
) (
	input  logic                            clk,
	input  logic                            i_arst_n,
	input  logic                            i_rx,
	output logic                            o_valid,
	output logic [uart_sys_pkg::BYTE_W-1:0] o_data
);

	localparam int CNT_W = (CLK_PER_BIT > 2) ? $clog2(CLK_PER_BIT) : 1;
	localparam int IDX_W = $clog2(uart_sys_pkg::BYTE_W);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLK_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLK_PER_BIT / 2 - 1);
	localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(uart_sys_pkg::BYTE_W - 1);

	logic                            rx_meta;
	logic                            rx_sync;
	logic                            rx_prev;
	uart_sys_pkg::rx_state_e         state;
	logic [CNT_W-1:0]                cnt;
	logic [IDX_W-1:0]                bit_idx;
	logic [uart_sys_pkg::BYTE_W-1:0] shreg;
	logic                            tick;

	assign tick = (cnt == '0); // current bit midpoint reached

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rx_meta <= 1'b1; // line idles high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
			state   <= uart_sys_pkg::RX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			o_valid <= 1'b0;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			o_valid <= 1'b0;
			if (!tick) begin
				cnt <= cnt - 1'b1;
			end
			case (state)
			uart_sys_pkg::RX_IDLE: begin
				if (rx_prev && !rx_sync) begin // falling edge of a start bit
					state <= uart_sys_pkg::RX_START;
					cnt   <= HALF_LAST;
				end
			end
			uart_sys_pkg::RX_START: begin
				if (tick) begin
					if (!rx_sync) begin
						state   <= uart_sys_pkg::RX_DATA;
						cnt     <= BIT_LAST;
						bit_idx <= '0;
					end else begin
						state <= uart_sys_pkg::RX_IDLE; // glitch, not a start bit
					end
				end
			end
			uart_sys_pkg::RX_DATA: begin
				if (tick) begin
					cnt     <= BIT_LAST;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == IDX_LAST) begin
						state <= uart_sys_pkg::RX_STOP;
					end
				end
			end
			uart_sys_pkg::RX_STOP: begin
				if (tick) begin
					state   <= uart_sys_pkg::RX_IDLE;
					o_valid <= rx_sync; // framing error drops the byte
				end
			end
			default: state <= uart_sys_pkg::RX_IDLE;
			endcase
		end
	end

	// data bits arrive lsb first and shift in from the top
	always_ff @(posedge clk) begin
		if (state == uart_sys_pkg::RX_DATA && tick) begin
			shreg <= {rx_sync, shreg[uart_sys_pkg::BYTE_W-1:1]};
		end
		if (state == uart_sys_pkg::RX_STOP && tick) begin
			o_data <= shreg;
		end
	end

endmodule

/* source/uart_tx.sv */
////////////////////////////////////////////////////////////
// Reply queue and UART transmitter
////////////////////////////////////////////////////////////

module uart_tx #(
	parameter int CLK_PER_BIT = 16,
	parameter int TX_DEPTH    = 4
) (
	input  logic                            clk,
	input  logic                            i_arst_n,
	input  logic                            i_valid,
	input  logic [uart_sys_pkg::BYTE_W-1:0] i_data,
	output logic                            o_credit,
	output logic                            o_tx
);

	localparam int CNT_W = (CLK_PER_BIT > 2) ? $clog2(CLK_PER_BIT) : 1;
	localparam int PTR_W = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
	localparam int OCC_W = $clog2(TX_DEPTH + 1);
	localparam int IDX_W = $clog2(uart_sys_pkg::BYTE_W);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLK_PER_BIT - 1);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(uart_sys_pkg::BYTE_W - 1);

	logic [uart_sys_pkg::BYTE_W-1:0] queue [TX_DEPTH];
	logic [PTR_W-1:0]                wr_ptr;
	logic [PTR_W-1:0]                rd_ptr;
	logic [OCC_W-1:0]                occ;
	uart_sys_pkg::tx_state_e         state;
	logic [CNT_W-1:0]                cnt;
	logic [IDX_W-1:0]                bit_idx;
	logic [uart_sys_pkg::BYTE_W-1:0] shreg;
	logic                            tick;
	logic                            deq;
	logic                            line_bit;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(TX_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign tick = (cnt == '0);
	assign deq  = (state == uart_sys_pkg::TX_IDLE) && (occ != '0); // next frame may start

	always_comb begin
		case (state)
		uart_sys_pkg::TX_START: line_bit = 1'b0;
		uart_sys_pkg::TX_DATA:  line_bit = shreg[0];
		default:                line_bit = 1'b1; // idle and stop bit
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			occ      <= '0;
			state    <= uart_sys_pkg::TX_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			o_credit <= 1'b0;
			o_tx     <= 1'b1;
		end else begin
			if (i_valid) begin
				wr_ptr <= ptr_inc(wr_ptr); // credits keep the queue from overflowing
			end
			if (deq) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			occ      <= occ + OCC_W'(i_valid) - OCC_W'(deq);
			o_credit <= deq; // slot is free again
			o_tx     <= line_bit; // line trails the state by one cycle
			if (!tick) begin
				cnt <= cnt - 1'b1;
			end
			case (state)
			uart_sys_pkg::TX_IDLE: begin
				if (deq) begin
					state <= uart_sys_pkg::TX_START;
					cnt   <= BIT_LAST;
				end
			end
			uart_sys_pkg::TX_START: begin
				if (tick) begin
					state   <= uart_sys_pkg::TX_DATA;
					cnt     <= BIT_LAST;
					bit_idx <= '0;
				end
			end
			uart_sys_pkg::TX_DATA: begin
				if (tick) begin
					cnt     <= BIT_LAST;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == IDX_LAST) begin
						state <= uart_sys_pkg::TX_STOP;
					end
				end
			end
			uart_sys_pkg::TX_STOP: begin
				if (tick) begin
					state <= uart_sys_pkg::TX_IDLE;
				end
			end
			default: state <= uart_sys_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			queue[wr_ptr] <= i_data;
		end
		if (deq) begin
			shreg <= queue[rd_ptr];
		end else if (state == uart_sys_pkg::TX_DATA && tick) begin
			shreg <= shreg >> 1; // lsb goes out first
		end
	end

endmodule

/* source/cmd_engine.sv */
////////////////////////////////////////////////////////////
// Command decoder with credit gated replies
////////////////////////////////////////////////////////////

module cmd_engine #(
	parameter int TX_DEPTH = 4
) (
	input  logic                            clk,
	input  logic                            i_arst_n,
	input  logic                            i_rx_valid,
	input  logic [uart_sys_pkg::BYTE_W-1:0] i_rx_data,
	input  logic [3:0]                      i_sw,
	input  logic                            i_tx_credit,
	output logic                            o_tx_valid,
	output logic [uart_sys_pkg::BYTE_W-1:0] o_tx_data,
	output logic [3:0]                      o_led
);

	localparam int CRD_W = $clog2(TX_DEPTH + 1);

	logic [CRD_W-1:0]                credits;
	logic                            pend_valid;
	logic [uart_sys_pkg::BYTE_W-1:0] pend_cmd;
	logic [uart_sys_pkg::BYTE_W-1:0] pend_reply;
	logic [uart_sys_pkg::BYTE_W-1:0] new_reply;
	logic [uart_sys_pkg::BYTE_W-1:0] send_cmd;
	logic [uart_sys_pkg::BYTE_W-1:0] send_reply;
	uart_sys_pkg::cmd_op_e           rx_op;
	uart_sys_pkg::cmd_op_e           send_op;
	logic                            has_credit;
	logic                            send;
	logic                            capture;

	// the reply is decided when the command arrives
	always_comb begin
		rx_op = uart_sys_pkg::cmd_op_e'(i_rx_data[uart_sys_pkg::BYTE_W-1 -: 4]);
		case (rx_op)
		uart_sys_pkg::OP_SET_LED: new_reply = i_rx_data;
		uart_sys_pkg::OP_PING:    new_reply = i_rx_data;
		uart_sys_pkg::OP_READ_SW: new_reply = {uart_sys_pkg::OP_READ_SW, i_sw};
		default:                  new_reply = uart_sys_pkg::REPLY_BAD;
		endcase
	end

	assign has_credit = (credits != '0);
	assign send       = has_credit && (pend_valid || i_rx_valid); // pending reply goes first
	assign capture    = i_rx_valid && !pend_valid && !has_credit;
	assign send_cmd   = pend_valid ? pend_cmd : i_rx_data;
	assign send_reply = pend_valid ? pend_reply : new_reply;
	assign send_op    = uart_sys_pkg::cmd_op_e'(send_cmd[uart_sys_pkg::BYTE_W-1 -: 4]);

	// A command that arrives while a reply is still pending is lost.
	// With one reply per command and at least two queue entries the host
	// cannot get ahead of the transmitter at equal bit rates.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			credits    <= CRD_W'(TX_DEPTH); // one credit per queue entry
			pend_valid <= 1'b0;
			o_tx_valid <= 1'b0;
			o_led      <= '0;
		end else begin
			credits    <= credits - CRD_W'(send) + CRD_W'(i_tx_credit);
			o_tx_valid <= send;
			if (capture) begin
				pend_valid <= 1'b1;
			end else if (send) begin
				pend_valid <= 1'b0;
			end
			if (send && send_op == uart_sys_pkg::OP_SET_LED) begin
				o_led <= send_cmd[3:0]; // leds change together with the reply
			end
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			o_tx_data <= send_reply;
		end
		if (capture) begin
			pend_cmd   <= i_rx_data;
			pend_reply <= new_reply;
		end
	end

endmodule

/* source/sw_debounce.sv */
////////////////////////////////////////////////////////////
// Switch debouncer
////////////////////////////////////////////////////////////

module sw_debounce #(
	parameter int DEBOUNCE_CYCLES = 8
) (
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic [3:0] i_sw,
	output logic [3:0] o_sw
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(DEBOUNCE_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(DEBOUNCE_CYCLES - 1);

	logic [3:0]       sw_meta;
	logic [3:0]       sw_sync;
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sw_meta <= '0;
			sw_sync <= '0;
			cnt     <= '0;
			o_sw    <= '0;
		end else begin
			sw_meta <= i_sw;
			sw_sync <= sw_meta;
			if (sw_meta != sw_sync) begin
				cnt <= '0; // any bit moving restarts the wait
			end else if (cnt != CNT_DONE) begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_LOAD) begin
					o_sw <= sw_sync; // loads as the count reaches its end
				end
			end
		end
	end

endmodule

/* source/uart_sys.sv */
////////////////////////////////////////////////////////////
// UART command system top level
////////////////////////////////////////////////////////////

module uart_sys #(
	parameter int CLK_PER_BIT     = 16,
	parameter int TX_DEPTH        = 4,
	parameter int DEBOUNCE_CYCLES = 8
) (
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic [3:0] i_sw,
	input  logic       i_uart_rx,
	output logic       o_uart_tx,
	output logic [3:0] o_led
);

	logic                            rx_valid;
	logic [uart_sys_pkg::BYTE_W-1:0] rx_data;
	logic                            tx_valid;
	logic [uart_sys_pkg::BYTE_W-1:0] tx_data;
	logic                            tx_credit;
	logic [3:0]                      sw_stable;

	uart_rx #(
		.CLK_PER_BIT (CLK_PER_BIT)
	) u_uart_rx (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_rx     (i_uart_rx),
		.o_valid  (rx_valid),
		.o_data   (rx_data)
	);

	cmd_engine #(
		.TX_DEPTH (TX_DEPTH)
	) u_cmd_engine (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_rx_valid  (rx_valid),
		.i_rx_data   (rx_data),
		.i_sw        (sw_stable),
		.i_tx_credit (tx_credit),
		.o_tx_valid  (tx_valid),
		.o_tx_data   (tx_data),
		.o_led       (o_led)
	);

	uart_tx #(
		.CLK_PER_BIT (CLK_PER_BIT),
		.TX_DEPTH    (TX_DEPTH)
	) u_uart_tx (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (tx_valid),
		.i_data   (tx_data),
		.o_credit (tx_credit),
		.o_tx     (o_uart_tx)
	);

	sw_debounce #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) u_sw_debounce (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_sw     (i_sw),
		.o_sw     (sw_stable)
	);

endmodule

/* tests/uart_sys_asserts.sv */
////////////////////////////////////////////////////////////
// Credit and serial line assertions
////////////////////////////////////////////////////////////

module uart_sys_asserts #(
	parameter int TX_DEPTH = 4
) (
	input logic                             clk,
	input logic                             i_arst_n,
	input logic                             i_send,
	input logic [$clog2(TX_DEPTH + 1)-1:0] i_credits,
	input logic                             i_tx_idle,
	input logic                             i_tx
);

	// a reply may only enter the queue while a slot is free
	credit_gate: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_send |-> (i_credits != '0))
		else $error("reply sent with zero credits");

	credit_max: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_credits <= TX_DEPTH)
		else $error("credit count above queue depth");

	line_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_tx_idle |-> i_tx) // the line lags the state and the stop bit before idle is high
		else $error("serial line low while transmitter idle");

endmodule

bind cmd_engine uart_sys_asserts #(.TX_DEPTH(TX_DEPTH)) u_engine_asserts (
	.clk(clk), .i_arst_n(i_arst_n), .i_send(1'b0), .i_credits(credits),
	.i_tx_idle(1'b0), .i_tx(1'b1)
);

// the queue counts its free slots as credits
bind uart_tx uart_sys_asserts #(.TX_DEPTH(TX_DEPTH)) u_tx_asserts (
	.clk(clk), .i_arst_n(i_arst_n), .i_send(i_valid),
	.i_credits(OCC_W'(TX_DEPTH) - occ),
	.i_tx_idle(state == uart_sys_pkg::TX_IDLE), .i_tx(o_tx)
);

/* tests/uart_sys_tb.sv */
////////////////////////////////////////////////////////////
// UART command system testbench
////////////////////////////////////////////////////////////

module uart_sys_tb;

	localparam int CLK_PER_BIT     = 16;
	localparam int TX_DEPTH        = 4;
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int REPLY_TIMEOUT   = 20 * 10 * CLK_PER_BIT; // cycles for twenty frames

	logic       clk;
	logic       i_arst_n;
	logic [3:0] i_sw;
	logic       i_uart_rx;
	logic       o_uart_tx;
	logic [3:0] o_led;
	logic [7:0] exp_q[$];
	logic [7:0] rx_q[$];
	logic [31:0] lfsr;
	int         n_err;
	int         n_timeout;
	int         n_checked;

	uart_sys #(
		.CLK_PER_BIT     (CLK_PER_BIT),
		.TX_DEPTH        (TX_DEPTH),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) dut (
		.clk       (clk),
		.i_arst_n  (i_arst_n),
		.i_sw      (i_sw),
		.i_uart_rx (i_uart_rx),
		.o_uart_tx (o_uart_tx),
		.o_led     (o_led)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// expected reply from the command byte and the switches the host holds
	function automatic logic [7:0] expected_reply(input logic [7:0] cmd, input logic [3:0] sw);
		logic [7:0] r;
		case (cmd[7:4])
		4'h1:    r = cmd;
		4'h2:    r = {4'h2, sw};
		4'h3:    r = cmd;
		default: r = uart_sys_pkg::REPLY_BAD;
		endcase
		return r;
	endfunction

	// moves opcodes 1 to 3 out of the known range
	function automatic logic [7:0] to_unknown(input logic [7:0] v);
		logic [7:0] r;
		r = v;
		if (r[7:4] >= 4'h1 && r[7:4] <= 4'h3) begin
			r[7:4] = r[7:4] + 4'h4;
		end
		return r;
	endfunction

	task automatic rand_bits(input int n, output logic [7:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[6:0], lfsr[0]}; // lsb of the lfsr state becomes the next bit
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int         i;
		frame = {1'b1, b, 1'b0}; // start bit first, stop bit last
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			i_uart_rx <= frame[i];
			repeat (CLK_PER_BIT - 1) @(posedge clk);
		end
	endtask

	task automatic send_cmd(input logic [7:0] cmd);
		exp_q.push_back(expected_reply(cmd, i_sw));
		send_byte(cmd);
	endtask

	task automatic wait_replies();
		int t;
		t = 0;
		while (exp_q.size() != 0 && t < REPLY_TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (exp_q.size() != 0) begin
			$display("timed out waiting for %0d replies on o_uart_tx", exp_q.size());
			n_timeout++;
			exp_q.delete();
		end
	endtask

	// host receiver samples each bit at its midpoint
	initial begin
		logic [7:0] b;
		int         i;
		forever begin
			@(negedge clk);
			if (o_uart_tx === 1'b0) begin
				repeat (CLK_PER_BIT / 2) @(negedge clk);
				if (o_uart_tx !== 1'b0) begin
					$display("start bit on o_uart_tx did not hold low");
					n_err++;
				end else begin
					for (i = 0; i < 8; i++) begin
						repeat (CLK_PER_BIT) @(negedge clk);
						b[i] = o_uart_tx;
					end
					repeat (CLK_PER_BIT) @(negedge clk);
					if (o_uart_tx !== 1'b1) begin
						$display("stop bit on o_uart_tx was low");
						n_err++;
					end
					rx_q.push_back(b);
				end
			end
		end
	end

	initial begin
		logic [7:0] got;
		logic [7:0] exp;
		forever begin
			@(posedge clk);
			while (rx_q.size() != 0) begin
				got = rx_q.pop_front();
				if (exp_q.size() == 0) begin
					$display("reply 0x%02h arrived with no command outstanding", got);
					n_err++;
				end else begin
					exp = exp_q.pop_front();
					n_checked++;
					if (got !== exp) begin
						$display("Error: o_uart_tx reply 0x%02h expected 0x%02h", got, exp);
						n_err++;
					end
				end
			end
		end
	end

	initial begin
		logic [7:0] v;
		logic [7:0] cmd;
		int         i;
		i_arst_n  = 1'b0;
		i_sw      = 4'h0;
		i_uart_rx = 1'b1;
		lfsr      = 32'hc6a66e4f;
		n_err     = 0;
		n_timeout = 0;
		n_checked = 0;
		repeat (8) @(posedge clk);
		i_arst_n <= 1'b1;
		for (i = 0; i < 20; i++) begin // quiet line after reset
			@(negedge clk);
			if (o_uart_tx !== 1'b1) begin
				$display("Error: o_uart_tx 0x%h expected 0x1", o_uart_tx);
				n_err++;
			end
			if (o_led !== 4'h0) begin
				$display("Error: o_led 0x%h expected 0x0", o_led);
				n_err++;
			end
		end
		for (i = 0; i < 8; i++) begin
			rand_bits(4, v);
			cmd = {4'h1, v[3:0]};
			send_cmd(cmd);
			wait_replies();
			@(negedge clk);
			if (o_led !== cmd[3:0]) begin
				$display("Error: o_led 0x%h expected 0x%h", o_led, cmd[3:0]);
				n_err++;
			end
		end
		for (i = 0; i < 4; i++) begin
			rand_bits(4, v);
			@(posedge clk);
			i_sw <= v[3:0];
			repeat (40) @(posedge clk); // longer than the debounce delay
			send_cmd(8'h20);
			wait_replies();
		end
		for (i = 0; i < 8; i++) begin
			if (i % 2 == 0) begin
				rand_bits(4, v);
				cmd = {4'h3, v[3:0]};
			end else begin
				rand_bits(8, v);
				cmd = to_unknown(v);
			end
			send_cmd(cmd);
			wait_replies();
		end
		for (i = 0; i < 12; i++) begin // no gap between frames
			rand_bits((i % 4 == 3) ? 8 : 4, v);
			case (i % 4)
			0:       cmd = {4'h1, v[3:0]};
			1:       cmd = {4'h2, v[3:0]};
			2:       cmd = {4'h3, v[3:0]};
			default: cmd = to_unknown(v);
			endcase
			send_cmd(cmd);
		end
		wait_replies();
		repeat (4) @(posedge clk);
		$display("replies checked %0d, errors %0d, timeouts %0d", n_checked, n_err, n_timeout);
		if (n_err == 0 && n_timeout == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* tb.f */
source/uart_sys_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_engine.sv
source/sw_debounce.sv
source/uart_sys.sv
tests/uart_sys_asserts.sv
tests/uart_sys_tb.sv

/* Bender.yml */
package:
  name: uart_sys

sources:
  - files:
      - source/uart_sys_pkg.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - source/cmd_engine.sv
      - source/sw_debounce.sv
      - source/uart_sys.sv
  - target: test
    files:
      - tests/uart_sys_asserts.sv
      - tests/uart_sys_tb.sv
